// File: filelist.f
hw/z80_dp_pkg.sv
hw/z80_regfile.sv
hw/z80_special_regs.sv
hw/z80_alu.sv
hw/z80_bus_arbiter.sv
hw/z80_datapath.sv
sim/z80_dp_tb.sv

// File: hw/z80_alu.sv
`timescale 1ns/100ps
`default_nettype none

module z80_alu (
  input  wire                z80_dp_pkg::alu_op_e op,
  input  wire                z80_dp_pkg::byte_t   a_val,
  input  wire                z80_dp_pkg::byte_t   data_in,
  input  wire                z80_dp_pkg::byte_t   temp_val,
  input  wire                z80_dp_pkg::word_t   rd16_val,
  output z80_dp_pkg::byte_t  alu8,
  output z80_dp_pkg::word_t  alu16
);

  // TEMP widened for the 16-bit unit
  z80_dp_pkg::word_t temp_ze;
  z80_dp_pkg::word_t temp_se;

  assign temp_ze = {{z80_dp_pkg::BYTE_W{1'b0}}, temp_val};
  assign temp_se = {{z80_dp_pkg::BYTE_W{temp_val[z80_dp_pkg::BYTE_W-1]}}, temp_val};

  // --------------------
  // both adders decode the same op
  // sums simply wrap, no carry out
  always_comb begin
    case (op)
      z80_dp_pkg::ALU_INC: begin
        alu8  = a_val + 8'd1;
        alu16 = rd16_val + 16'd1;
      end
      z80_dp_pkg::ALU_DEC: begin
        alu8  = a_val - 8'd1;
        alu16 = rd16_val - 16'd1;
      end
      z80_dp_pkg::ALU_ADD: begin
        alu8  = a_val + data_in;
        alu16 = rd16_val + temp_ze;
      end
      // relative offsets, the byte unit sees no difference
      z80_dp_pkg::ALU_ADD_SE: begin
        alu8  = a_val + data_in;
        alu16 = rd16_val + temp_se;
      end
      default: begin
        alu8  = a_val;
        alu16 = rd16_val;
      end
    endcase
  end

endmodule : z80_alu

`default_nettype wire

// File: hw/z80_bus_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module z80_bus_arbiter (
  input  wire                z80_dp_pkg::uop_t  uop,
  input  wire                z80_dp_pkg::byte_t data_in,
  input  wire                z80_dp_pkg::byte_t rd8_val,
  input  wire                z80_dp_pkg::byte_t a_val,
  input  wire                z80_dp_pkg::byte_t temp_val,
  input  wire                z80_dp_pkg::byte_t alu8,
  input  wire                z80_dp_pkg::word_t rd16_val,
  input  wire                z80_dp_pkg::word_t mar_val,
  input  wire                z80_dp_pkg::word_t alu16,
  output z80_dp_pkg::byte_t  dbus,
  output z80_dp_pkg::byte_t  data_out,
  output z80_dp_pkg::word_t  abus,
  output z80_dp_pkg::word_t  addr_out,
  output logic               data_valid,
  output logic               addr_valid
);

  // --------------------
  // internal data bus
  // undriven bus falls back to the external input
  always_comb begin
    case (uop.dsrc)
      z80_dp_pkg::DSRC_REG:  dbus = rd8_val;
      z80_dp_pkg::DSRC_A:    dbus = a_val;
      z80_dp_pkg::DSRC_TEMP: dbus = temp_val;
      z80_dp_pkg::DSRC_ALU:  dbus = alu8;
      default:               dbus = data_in;
    endcase
  end

  // --------------------
  // internal address bus
  // idle bus reads as zero
  always_comb begin
    case (uop.asrc)
      z80_dp_pkg::ASRC_PAIR: abus = rd16_val;
      z80_dp_pkg::ASRC_MAR:  abus = mar_val;
      z80_dp_pkg::ASRC_ALU:  abus = alu16;
      default:               abus = '0;
    endcase
  end

  // external side sees a bus only while something internal drives it
  assign data_valid = (uop.dsrc != z80_dp_pkg::DSRC_EXT);
  assign addr_valid = (uop.asrc != z80_dp_pkg::ASRC_NONE);

  assign data_out = data_valid ? dbus : '0;
  assign addr_out = addr_valid ? abus : '0;

endmodule : z80_bus_arbiter

`default_nettype wire

// File: hw/z80_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module z80_datapath (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                z80_dp_pkg::uop_t  uop,
  input  wire                z80_dp_pkg::byte_t data_in,
  output z80_dp_pkg::byte_t  data_out,
  output logic               data_valid,
  output z80_dp_pkg::word_t  addr_out,
  output logic               addr_valid
);

  // --------------------
  // internal buses and block outputs
  z80_dp_pkg::byte_t dbus;
  z80_dp_pkg::word_t abus;
  z80_dp_pkg::byte_t rd8_val;
  z80_dp_pkg::word_t rd16_val;
  z80_dp_pkg::byte_t a_val;
  z80_dp_pkg::byte_t temp_val;
  z80_dp_pkg::word_t mar_val;
  z80_dp_pkg::byte_t alu8;
  z80_dp_pkg::word_t alu16;

  z80_regfile u_regfile (
    .clk(clk), .rst_n(rst_n), .uop(uop), .dbus(dbus), .abus(abus),
    .rd8_val(rd8_val), .rd16_val(rd16_val)
  );

  z80_special_regs u_special_regs (
    .clk(clk), .rst_n(rst_n), .uop(uop), .dbus(dbus), .abus(abus),
    .a_val(a_val), .temp_val(temp_val), .mar_val(mar_val)
  );

  // 8-bit side works on A and the pins, 16-bit side on a pair and TEMP
  z80_alu u_alu (
    .op(uop.alu_op), .a_val(a_val), .data_in(data_in), .temp_val(temp_val),
    .rd16_val(rd16_val), .alu8(alu8), .alu16(alu16)
  );

  z80_bus_arbiter u_bus_arbiter (
    .uop(uop), .data_in(data_in), .rd8_val(rd8_val), .a_val(a_val),
    .temp_val(temp_val), .alu8(alu8), .rd16_val(rd16_val),
    .mar_val(mar_val), .alu16(alu16),
    .dbus(dbus), .data_out(data_out), .abus(abus), .addr_out(addr_out),
    .data_valid(data_valid), .addr_valid(addr_valid)
  );

endmodule : z80_datapath

`default_nettype wire

// File: hw/z80_dp_pkg.sv
`default_nettype none

package z80_dp_pkg;

  // --------------------
  // widths and sizes
  localparam int BYTE_W   = 8;
  localparam int WORD_W   = 16;
  // fourteen main bytes, six of them with an alternate
  localparam int NUM_REG8 = 14;
  localparam int NUM_ALT  = 6;

  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [WORD_W-1:0] word_t;

  // --------------------
  // register names
  // byte order matters since pair n lives at bytes 2n and 2n+1
  typedef enum logic [3:0] {
    R8_B, R8_C, R8_D, R8_E, R8_H, R8_L,
    R8_IXH, R8_IXL, R8_IYH, R8_IYL,
    R8_SPH, R8_SPL, R8_PCH, R8_PCL,
    R8_NONE = 4'd15
  } reg8_e;

  typedef enum logic [2:0] {
    P_BC, P_DE, P_HL, P_IX, P_IY, P_SP, P_PC,
    P_NONE
  } pair_e;

  // --------------------
  // opcodes and bus sources
  // every zero encoding is the idle choice
  typedef enum logic [2:0] {
    RF_NONE, RF_LD8, RF_LD16, RF_EXX, RF_EX_DE_HL
  } rf_op_e;

  typedef enum logic [2:0] {
    ALU_PASS, ALU_INC, ALU_DEC, ALU_ADD, ALU_ADD_SE
  } alu_op_e;

  // DSRC_EXT leaves the data bus undriven so it carries data_in
  typedef enum logic [2:0] {
    DSRC_EXT, DSRC_REG, DSRC_A, DSRC_TEMP, DSRC_ALU
  } dsrc_e;

  typedef enum logic [1:0] {
    ASRC_NONE, ASRC_PAIR, ASRC_MAR, ASRC_ALU
  } asrc_e;

  // one micro-op per clock from the sequencer
  typedef struct packed {
    rf_op_e  rf_op;
    reg8_e   ld8;
    pair_e   ld16;
    reg8_e   rd8;
    pair_e   rd16;
    dsrc_e   dsrc;
    asrc_e   asrc;
    alu_op_e alu_op;
    logic    ld_a;
    logic    ex_af;
    logic    ld_temp;
    logic    ld_marh;
    logic    ld_marl;
  } uop_t;

endpackage : z80_dp_pkg

`default_nettype wire

// File: hw/z80_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module z80_regfile (
  input  wire                z80_dp_pkg::uop_t  uop,
  input  wire                clk,
  input  wire                rst_n,
  input  wire                z80_dp_pkg::byte_t dbus,
  input  wire                z80_dp_pkg::word_t abus,
  output z80_dp_pkg::byte_t  rd8_val,
  output z80_dp_pkg::word_t  rd16_val
);

  // --------------------
  // storage
  // main bytes in reg8_e order
  z80_dp_pkg::byte_t rf     [z80_dp_pkg::NUM_REG8];
  // alternates exist for B C D E H L only
  // so index i here shadows rf[i]
  z80_dp_pkg::byte_t rf_alt [z80_dp_pkg::NUM_ALT];

  // byte indices of the read and load pairs
  logic [3:0] rd_hi;
  logic [3:0] rd_lo;
  logic [3:0] ld_hi;
  logic [3:0] ld_lo;

  // pair n is high byte 2n and low byte 2n+1
  assign rd_hi = {uop.rd16, 1'b0};
  assign rd_lo = {uop.rd16, 1'b1};
  assign ld_hi = {uop.ld16, 1'b0};
  assign ld_lo = {uop.ld16, 1'b1};

  // --------------------
  // read ports
  // both are combinational, no select gives zero
  always_comb begin
    if (uop.rd8 == z80_dp_pkg::R8_NONE) begin
      rd8_val = '0;
    end else begin
      rd8_val = rf[uop.rd8];
    end
  end

  always_comb begin
    if (uop.rd16 == z80_dp_pkg::P_NONE) begin
      rd16_val = '0;
    end else begin
      rd16_val = {rf[rd_hi], rf[rd_lo]};
    end
  end

  // --------------------
  // write port
  // only one action per micro-op, chosen by rf_op
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < z80_dp_pkg::NUM_REG8; i++) begin
        rf[i] <= '0;
      end
      for (int j = 0; j < z80_dp_pkg::NUM_ALT; j++) begin
        rf_alt[j] <= '0;
      end
    end else begin
      case (uop.rf_op)

        // single byte from the data bus
        z80_dp_pkg::RF_LD8: begin
          if (uop.ld8 != z80_dp_pkg::R8_NONE) begin
            rf[uop.ld8] <= dbus;
          end
        end

        // whole pair from the address bus
        z80_dp_pkg::RF_LD16: begin
          if (uop.ld16 != z80_dp_pkg::P_NONE) begin
            rf[ld_hi] <= abus[z80_dp_pkg::WORD_W-1:z80_dp_pkg::BYTE_W];
            rf[ld_lo] <= abus[z80_dp_pkg::BYTE_W-1:0];
          end
        end

        // exx trades BC DE HL with the alternate set
        // IX IY SP PC are left alone
        z80_dp_pkg::RF_EXX: begin
          for (int k = 0; k < z80_dp_pkg::NUM_ALT; k++) begin
            rf[k]     <= rf_alt[k];
            rf_alt[k] <= rf[k];
          end
        end

        // ex de,hl on the main set only
        z80_dp_pkg::RF_EX_DE_HL: begin
          rf[z80_dp_pkg::R8_D] <= rf[z80_dp_pkg::R8_H];
          rf[z80_dp_pkg::R8_E] <= rf[z80_dp_pkg::R8_L];
          rf[z80_dp_pkg::R8_H] <= rf[z80_dp_pkg::R8_D];
          rf[z80_dp_pkg::R8_L] <= rf[z80_dp_pkg::R8_E];
        end

        // RF_NONE and unused codes hold everything
        default: begin
        end

      endcase
    end
  end

endmodule : z80_regfile

`default_nettype wire

// File: hw/z80_special_regs.sv
`timescale 1ns/100ps
`default_nettype none

module z80_special_regs (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                z80_dp_pkg::uop_t  uop,
  input  wire                z80_dp_pkg::byte_t dbus,
  input  wire                z80_dp_pkg::word_t abus,
  output z80_dp_pkg::byte_t  a_val,
  output z80_dp_pkg::byte_t  temp_val,
  output z80_dp_pkg::word_t  mar_val
);

  z80_dp_pkg::byte_t a_q;
  z80_dp_pkg::byte_t a_alt_q;
  z80_dp_pkg::byte_t temp_q;
  z80_dp_pkg::word_t mar_q;

  // --------------------
  // accumulator pair
  // ex af takes priority over a plain load
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q     <= '0;
      a_alt_q <= '0;
    end else if (uop.ex_af) begin
      a_q     <= a_alt_q;
      a_alt_q <= a_q;
    end else if (uop.ld_a) begin
      a_q <= dbus;
    end
  end

  // holding byte for displacements and immediates
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      temp_q <= '0;
    end else if (uop.ld_temp) begin
      temp_q <= dbus;
    end
  end

  // --------------------
  // MAR
  // each half loads from its own half of the address bus
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mar_q <= '0;
    end else begin
      if (uop.ld_marh) begin
        mar_q[z80_dp_pkg::WORD_W-1:z80_dp_pkg::BYTE_W] <=
          abus[z80_dp_pkg::WORD_W-1:z80_dp_pkg::BYTE_W];
      end
      if (uop.ld_marl) begin
        mar_q[z80_dp_pkg::BYTE_W-1:0] <= abus[z80_dp_pkg::BYTE_W-1:0];
      end
    end
  end

  assign a_val    = a_q;
  assign temp_val = temp_q;
  assign mar_val  = mar_q;

endmodule : z80_special_regs

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# builds the datapath testbench with Verilator and runs it
# the stim file path is relative to the project root, so run from there
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f filelist.f --top-module z80_dp_tb -o z80_dp_sim \
  && ./obj_dir/z80_dp_sim \
  || exit 1

// File: sim/z80_dp_stim.txt
# rf ld8 ld16 rd8 rd16 dsrc asrc alu ld_a ex_af ld_temp ld_marh ld_marl data_in
#   then expected data_out data_valid addr_out addr_valid, all hex, one line per cycle
# idle right after reset
0 0 0 0 0 0 0 0 0 0 0 0 0 00 00 0 0000 0
# byte loads from data_in, each finished pair read on the address bus
1 0 0 0 0 0 0 0 0 0 0 0 0 11 00 0 0000 0
1 1 0 0 0 0 0 0 0 0 0 0 0 22 00 0 0000 0
1 2 0 0 0 0 1 0 0 0 0 0 0 33 00 0 1122 1
1 3 0 0 0 0 0 0 0 0 0 0 0 44 00 0 0000 0
1 4 0 0 1 0 1 0 0 0 0 0 0 55 00 0 3344 1
1 5 0 0 0 0 0 0 0 0 0 0 0 66 00 0 0000 0
1 6 0 0 2 0 1 0 0 0 0 0 0 77 00 0 5566 1
1 7 0 0 0 0 0 0 0 0 0 0 0 88 00 0 0000 0
1 8 0 0 3 0 1 0 0 0 0 0 0 99 00 0 7788 1
1 9 0 0 0 0 0 0 0 0 0 0 0 aa 00 0 0000 0
1 a 0 0 4 0 1 0 0 0 0 0 0 bb 00 0 99aa 1
1 b 0 0 0 0 0 0 0 0 0 0 0 cc 00 0 0000 0
1 c 0 0 5 0 1 0 0 0 0 0 0 dd 00 0 bbcc 1
1 d 0 0 0 0 0 0 0 0 0 0 0 ee 00 0 0000 0
# data bus reads, B copied into TEMP and IXL into A
0 0 0 d 6 1 1 0 0 0 0 0 0 00 ee 1 ddee 1
0 0 0 0 0 1 0 0 0 0 1 0 0 00 11 1 0000 0
0 0 0 7 0 1 0 0 1 0 0 0 0 00 88 1 0000 0
# IX gets BC plus TEMP through alu16
2 0 3 0 0 3 3 3 0 0 0 0 0 00 11 1 1133 1
0 0 0 0 3 2 1 0 0 0 0 0 0 00 88 1 1133 1
# alu opcodes
0 0 0 0 0 4 3 1 0 0 0 0 0 00 89 1 1123 1
0 0 0 0 1 4 3 2 0 0 0 0 0 00 87 1 3343 1
0 0 0 0 2 4 3 3 0 0 0 0 0 10 98 1 5577 1
0 0 0 0 0 0 0 0 1 0 0 0 0 ff 00 0 0000 0
0 0 0 0 0 0 1 0 0 0 1 0 0 80 00 0 1122 1
0 0 0 0 2 4 3 1 0 0 0 0 0 00 00 1 5567 1
0 0 0 0 2 4 3 3 0 0 0 0 0 02 01 1 55e6 1
0 0 0 0 2 4 3 4 0 0 0 0 0 03 02 1 54e6 1
# MAR high, low, then both
0 0 0 0 0 0 1 0 0 0 0 1 0 00 00 0 1122 1
0 0 0 0 0 0 2 0 0 0 0 0 0 00 00 0 1100 1
0 0 0 0 1 0 1 0 0 0 0 0 1 00 00 0 3344 1
0 0 0 0 0 0 2 0 0 0 0 0 0 00 00 0 1144 1
0 0 0 0 5 0 3 1 0 0 0 1 1 00 00 0 bbcd 1
0 0 0 0 0 0 2 0 0 0 0 0 0 00 00 0 bbcd 1
# exx, load BC on the alternate side, exx back
3 0 0 4 0 1 1 0 0 0 0 0 0 00 55 1 1122 1
0 0 0 5 0 1 1 0 0 0 0 0 0 00 00 1 0000 1
2 0 0 0 2 0 3 1 0 0 0 0 0 00 00 0 0001 1
3 0 0 0 0 0 1 0 0 0 0 0 0 00 00 0 0001 1
0 0 0 4 0 1 1 0 0 0 0 0 0 00 55 1 1122 1
0 0 0 2 3 1 1 0 0 0 0 0 0 00 33 1 1133 1
# ex af wins over ld_a, then swaps back
0 0 0 0 0 2 0 0 1 1 0 0 0 00 ff 1 0000 0
0 0 0 0 0 2 0 0 0 1 0 0 0 00 00 1 0000 0
0 0 0 0 0 2 0 0 0 0 0 0 0 00 ff 1 0000 0
# ex de,hl
4 0 0 4 1 1 1 0 0 0 0 0 0 00 55 1 3344 1
0 0 0 2 1 1 1 0 0 0 0 0 0 00 55 1 5566 1
0 0 0 5 2 1 1 0 0 0 0 0 0 00 44 1 3344 1
0 0 0 0 0 0 0 0 0 0 0 0 0 00 00 0 0000 0

// File: sim/z80_dp_tb.sv
`timescale 1ns/100ps
`default_nettype none

module z80_dp_tb;

  // --------------------
  // timing
  localparam int CLK_PERIOD     = 40;
  localparam int DRIVE_DLY      = 2;
  // sample 5 ns ahead of the next rising edge
  localparam int CHECK_DLY      = CLK_PERIOD - 5 - DRIVE_DLY;
  localparam int RST_CYCLES     = 2;
  localparam int NUM_FIELDS     = 18;
  localparam int TIMEOUT_MARGIN = 20;

  // one parsed stim line with stimulus first and expected outputs after
  typedef struct packed {
    z80_dp_pkg::uop_t  uop;
    z80_dp_pkg::byte_t din;
    z80_dp_pkg::byte_t exp_dout;
    logic              exp_dvalid;
    z80_dp_pkg::word_t exp_addr;
    logic              exp_avalid;
  } stim_row_t;

  logic              clk;
  logic              rst_n;
  z80_dp_pkg::uop_t  uop;
  z80_dp_pkg::byte_t data_in;
  z80_dp_pkg::byte_t data_out;
  logic              data_valid;
  z80_dp_pkg::word_t addr_out;
  logic              addr_valid;

  stim_row_t rows[$];
  int        cycle_count = 0;
  int        cycle_limit = 0;

  z80_datapath UUT (
    .clk(clk), .rst_n(rst_n), .uop(uop), .data_in(data_in),
    .data_out(data_out), .data_valid(data_valid),
    .addr_out(addr_out), .addr_valid(addr_valid)
  );

  // --------------------
  // clock and watchdog
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // limit is set once the stim file has been read
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      fail_run("timeout: the stim sequence did not finish within the cycle limit");
    end
  end

  // --------------------
  // helpers
  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // narrow signals are zero-padded by the caller
  task automatic check_val(input string name, input logic [15:0] actual,
                           input logic [15:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("MISMATCH at %0d ns: %s actual %h expected %h",
                         $time, name, actual, expected));
    end
  endtask

  // lines starting with # are comments
  // blank lines are skipped
  task automatic read_stim();
    int          fd;
    int          cnt;
    string       line;
    logic [15:0] fld [NUM_FIELDS];
    stim_row_t   row;
    fd = $fopen("sim/z80_dp_stim.txt", "r");
    if (fd == 0) begin
      fail_run("could not open the stim file sim/z80_dp_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        cnt  = $fgets(line, fd);
        if (cnt > 0 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                        fld[6], fld[7], fld[8], fld[9], fld[10], fld[11],
                        fld[12], fld[13], fld[14], fld[15], fld[16], fld[17]);
          if (cnt == NUM_FIELDS) begin
            row              = '0;
            row.uop.rf_op    = z80_dp_pkg::rf_op_e'(fld[0][2:0]);
            row.uop.ld8      = z80_dp_pkg::reg8_e'(fld[1][3:0]);
            row.uop.ld16     = z80_dp_pkg::pair_e'(fld[2][2:0]);
            row.uop.rd8      = z80_dp_pkg::reg8_e'(fld[3][3:0]);
            row.uop.rd16     = z80_dp_pkg::pair_e'(fld[4][2:0]);
            row.uop.dsrc     = z80_dp_pkg::dsrc_e'(fld[5][2:0]);
            row.uop.asrc     = z80_dp_pkg::asrc_e'(fld[6][1:0]);
            row.uop.alu_op   = z80_dp_pkg::alu_op_e'(fld[7][2:0]);
            row.uop.ld_a     = fld[8][0];
            row.uop.ex_af    = fld[9][0];
            row.uop.ld_temp  = fld[10][0];
            row.uop.ld_marh  = fld[11][0];
            row.uop.ld_marl  = fld[12][0];
            row.din          = fld[13][7:0];
            row.exp_dout     = fld[14][7:0];
            row.exp_dvalid   = fld[15][0];
            row.exp_addr     = fld[16];
            row.exp_avalid   = fld[17][0];
            rows.push_back(row);
          end else if (cnt > 0) begin
            fail_run("a line of the stim file does not hold 18 fields");
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // --------------------
  // main sequence
  initial begin
    rst_n     = 1'b0;
    uop       = '0;
    data_in   = '0;
    read_stim();
    cycle_limit = rows.size() + TIMEOUT_MARGIN;

    repeat (RST_CYCLES) @(posedge clk);
    #(DRIVE_DLY);
    rst_n = 1'b1;

    // one micro-op per cycle
    // outputs are combinational and settle well before the check point
    foreach (rows[i]) begin
      uop     = rows[i].uop;
      data_in = rows[i].din;
      #(CHECK_DLY);
      check_val("data_out", {8'h00, data_out}, {8'h00, rows[i].exp_dout});
      check_val("data_valid", {15'h0000, data_valid}, {15'h0000, rows[i].exp_dvalid});
      check_val("addr_out", addr_out, rows[i].exp_addr);
      check_val("addr_valid", {15'h0000, addr_valid}, {15'h0000, rows[i].exp_avalid});
      @(posedge clk);
      #(DRIVE_DLY);
    end

    if (rows.size() > 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      fail_run("the stim file held no usable lines");
    end
  end

endmodule : z80_dp_tb

`default_nettype wire
